// File: run.sh
#!/bin/sh
# build the square-root accelerator testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module sqrt_accel_tb \
    -f verilog.f -o sim_sqrt_accel > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_sqrt_accel > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^all tests passed$" sim.log; then
    exit 0
fi
echo "expected result line missing from sim.log"
exit 1

// File: source/axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axil_regs #(
    parameter int NUM_ENGINES = 2
) (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire sqrt_pkg::axil_req_t              axil_req,
    output sqrt_pkg::axil_rsp_t                   axil_rsp,
    input  wire logic [NUM_ENGINES-1:0]           busy,
    output logic [NUM_ENGINES-1:0]                go,
    output sqrt_pkg::job_t                        job,
    output logic                                  clear,
    output logic [sqrt_pkg::SLOT_W-1:0]           clear_slot,
    output logic [sqrt_pkg::SLOT_W-1:0]           rd_slot,
    input  wire logic [sqrt_pkg::DATA_W-1:0]      rd_root,
    input  wire logic [sqrt_pkg::NUM_SLOTS-1:0]   valid_mask
);
    localparam int AW = sqrt_pkg::ADDR_W;
    localparam int SW = sqrt_pkg::SLOT_W;
    localparam logic [AW-1:0] SLOT_BASE = sqrt_pkg::SLOT_BASE;

    sqrt_pkg::job_t               job_q;
    logic                         wr_pend, wr_hit, wr_hit_q, wr_accept, bvalid_q;
    logic                         rd_pend, rd_status_q, rd_accept, rvalid_q;
    logic [sqrt_pkg::DATA_W-1:0]  rdata_q, status_word;
    logic [NUM_ENGINES-1:0]       first_idle;

    // the lowest-indexed idle engine takes the next job.
    always_comb begin
        first_idle = '0;
        for (int i = NUM_ENGINES - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                first_idle = '0;
                first_idle[i] = 1'b1;
            end
        end
    end

    // one write in flight at a time, and only while some engine can take it.
    assign wr_accept = axil_req.awvalid && axil_req.wvalid && !(&busy) &&
                       !wr_pend && !bvalid_q;
    assign wr_hit = (axil_req.awaddr[AW-1:SW+2] == SLOT_BASE[AW-1:SW+2]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_pend <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            wr_pend <= wr_accept;
            if (wr_pend) bvalid_q <= 1'b1;
            else if (axil_req.bready) bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            job_q.slot <= axil_req.awaddr[SW+1:2];
            job_q.operand <= axil_req.wdata;
            wr_hit_q <= wr_hit;
        end
    end

    assign go = (wr_pend && wr_hit_q) ? first_idle : '0;
    assign clear = wr_pend && wr_hit_q; // a resubmitted slot loses its old root.
    assign clear_slot = job_q.slot;
    assign job = job_q;

    assign rd_accept = axil_req.arvalid && !rd_pend && !rvalid_q;
    assign rd_slot = axil_req.araddr[SW+1:2]; // the memory answers in the next cycle.

    always_comb begin
        status_word = '0;
        status_word[sqrt_pkg::NUM_SLOTS-1:0] = valid_mask;
        status_word[sqrt_pkg::NUM_SLOTS +: NUM_ENGINES] = busy;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            rd_pend <= rd_accept;
            if (rd_pend) rvalid_q <= 1'b1;
            else if (axil_req.rready) rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) rd_status_q <= (axil_req.araddr == sqrt_pkg::STATUS_ADDR);
        if (rd_pend) rdata_q <= rd_status_q ? status_word : rd_root;
    end

    always_comb begin
        axil_rsp.awready = wr_accept;
        axil_rsp.wready = wr_accept;
        axil_rsp.bvalid = bvalid_q;
        axil_rsp.bresp = sqrt_pkg::RESP_OKAY;
        axil_rsp.arready = rd_accept;
        axil_rsp.rvalid = rvalid_q;
        axil_rsp.rdata = rdata_q;
        axil_rsp.rresp = sqrt_pkg::RESP_OKAY;
    end

endmodule

`default_nettype wire

// File: source/fp_sqrt.sv
`timescale 1ns/1ps
`default_nettype none

module fp_sqrt #(
    parameter int FRAC_WIDTH = 16
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              go,
    input  wire sqrt_pkg::job_t    job,
    output logic                   busy,
    output logic                   req,
    input  wire logic              gnt,
    output sqrt_pkg::result_t      result
);
    localparam int DW = sqrt_pkg::DATA_W;
    localparam int ITERATIONS = (DW + FRAC_WIDTH + 1) / 2; // one root bit per cycle.
    localparam int RAD_W = 2 * ITERATIONS;
    localparam int ACC_W = DW + 4; // room for the remainder plus a sign bit.
    localparam int CNT_W = $clog2(ITERATIONS + 1);

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_REQ} state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;
    logic [ACC_W-1:0] acc, acc_in, acc_next, trial;
    logic [RAD_W-1:0] rad, rad_next;
    logic [DW-1:0]    root, root_next;
    logic             last_iter;

    assign last_iter = (state == S_RUN) && (cnt == CNT_W'(ITERATIONS - 1));
    assign busy = (state != S_IDLE);
    assign req = (state == S_REQ); // held with a stable result until the grant.

    // bring down the next two radicand bits and try the partial root with 01 appended.
    always_comb begin
        acc_in = {acc[ACC_W-3:0], rad[RAD_W-1 -: 2]};
        trial = acc_in - {2'b00, root, 2'b01};
        rad_next = {rad[RAD_W-3:0], 2'b00};
        if (trial[ACC_W-1]) begin
            acc_next = acc_in; // negative, keep the old remainder.
            root_next = {root[DW-2:0], 1'b0};
        end else begin
            acc_next = trial;
            root_next = {root[DW-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (go) state <= S_RUN;
                S_RUN: if (last_iter) state <= S_REQ;
                S_REQ: if (gnt) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && go) begin
            acc <= '0;
            root <= '0;
            rad <= RAD_W'(job.operand) << FRAC_WIDTH; // scale to keep the fraction bits.
            cnt <= '0;
            result.slot <= job.slot;
        end else if (state == S_RUN) begin
            acc <= acc_next;
            rad <= rad_next;
            root <= root_next;
            cnt <= cnt + 1'b1;
            if (last_iter) result.root <= root_next;
        end
    end

endmodule

`default_nettype wire

// File: source/result_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module result_arbiter #(
    parameter int NUM_ENGINES = 2
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic [NUM_ENGINES-1:0]  req,
    input  wire sqrt_pkg::result_t       results [NUM_ENGINES],
    output logic [NUM_ENGINES-1:0]       gnt,
    output logic                         wr_en,
    output sqrt_pkg::result_t            wr_result
);
    localparam int PTR_W = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1;

    logic [PTR_W-1:0] last; // index of the previous winner.
    logic             found;
    int               win;

    // search starts one past the last winner and wraps around.
    always_comb begin
        int idx;
        gnt = '0;
        found = 1'b0;
        win = 0;
        for (int k = 1; k <= NUM_ENGINES; k++) begin
            idx = (int'(last) + k) % NUM_ENGINES;
            if (!found && req[idx]) begin
                found = 1'b1;
                win = idx;
            end
        end
        if (found) gnt[win] = 1'b1;
    end

    assign wr_en = found;
    assign wr_result = results[win];

    always_ff @(posedge clk) begin
        if (!rst_n) last <= PTR_W'(NUM_ENGINES - 1); // engine 0 goes first.
        else if (found) last <= PTR_W'(win);
    end

endmodule

`default_nettype wire

// File: source/result_mem.sv
`timescale 1ns/1ps
`default_nettype none

module result_mem (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             wr_en,
    input  wire sqrt_pkg::result_t                wr_result,
    input  wire logic                             clear,
    input  wire logic [sqrt_pkg::SLOT_W-1:0]      clear_slot,
    input  wire logic [sqrt_pkg::SLOT_W-1:0]      rd_slot,
    output logic [sqrt_pkg::DATA_W-1:0]           rd_root,
    output logic [sqrt_pkg::NUM_SLOTS-1:0]        valid_mask
);
    logic [sqrt_pkg::DATA_W-1:0]    roots [sqrt_pkg::NUM_SLOTS];
    logic [sqrt_pkg::NUM_SLOTS-1:0] valid;

    always_ff @(posedge clk) begin
        if (wr_en) roots[wr_result.slot] <= wr_result.root;
        rd_root <= roots[rd_slot]; // registered read port.
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            if (clear) valid[clear_slot] <= 1'b0;
            if (wr_en) valid[wr_result.slot] <= 1'b1; // the write wins on a slot clash.
        end
    end

    assign valid_mask = valid;

endmodule

`default_nettype wire

// File: source/sqrt_accel.sv
`timescale 1ns/1ps
`default_nettype none

module sqrt_accel #(
    parameter int NUM_ENGINES = 2,
    parameter int FRAC_WIDTH = 16
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire sqrt_pkg::axil_req_t  axil_req,
    output sqrt_pkg::axil_rsp_t       axil_rsp
);
    logic [NUM_ENGINES-1:0]          busy, go, req, gnt;
    sqrt_pkg::job_t                  job;
    sqrt_pkg::result_t               results [NUM_ENGINES];
    sqrt_pkg::result_t               wr_result;
    logic                            wr_en, clear;
    logic [sqrt_pkg::SLOT_W-1:0]     clear_slot, rd_slot;
    logic [sqrt_pkg::DATA_W-1:0]     rd_root;
    logic [sqrt_pkg::NUM_SLOTS-1:0]  valid_mask;

    axil_regs #(.NUM_ENGINES(NUM_ENGINES)) u_regs (
        .clk(clk), .rst_n(rst_n),
        .axil_req(axil_req), .axil_rsp(axil_rsp),
        .busy(busy), .go(go), .job(job),
        .clear(clear), .clear_slot(clear_slot),
        .rd_slot(rd_slot), .rd_root(rd_root), .valid_mask(valid_mask)
    );

    for (genvar i = 0; i < NUM_ENGINES; i++) begin : g_engine
        fp_sqrt #(.FRAC_WIDTH(FRAC_WIDTH)) u_sqrt (
            .clk(clk), .rst_n(rst_n),
            .go(go[i]), .job(job), .busy(busy[i]),
            .req(req[i]), .gnt(gnt[i]), .result(results[i])
        );
    end

    result_arbiter #(.NUM_ENGINES(NUM_ENGINES)) u_arb (
        .clk(clk), .rst_n(rst_n),
        .req(req), .results(results), .gnt(gnt),
        .wr_en(wr_en), .wr_result(wr_result)
    );

    result_mem u_mem (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .wr_result(wr_result),
        .clear(clear), .clear_slot(clear_slot),
        .rd_slot(rd_slot), .rd_root(rd_root), .valid_mask(valid_mask)
    );

endmodule

`default_nettype wire

// File: source/sqrt_pkg.sv
`default_nettype none

package sqrt_pkg;

    parameter int DATA_W = 32; // operand, root and AXI data width.
    parameter int SLOT_W = 4;
    parameter int ADDR_W = 12;
    parameter int NUM_SLOTS = 1 << SLOT_W;

    parameter logic [ADDR_W-1:0] STATUS_ADDR = 12'h000;
    parameter logic [ADDR_W-1:0] SLOT_BASE = 12'h100; // slot s lives at SLOT_BASE + 4*s.

    parameter logic [1:0] RESP_OKAY = 2'b00;

    typedef struct packed {
        logic              awvalid;
        logic [ADDR_W-1:0] awaddr;
        logic              wvalid;
        logic [DATA_W-1:0] wdata;
        logic              bready;
        logic              arvalid;
        logic [ADDR_W-1:0] araddr;
        logic              rready;
    } axil_req_t;

    typedef struct packed {
        logic              awready;
        logic              wready;
        logic              bvalid;
        logic [1:0]        bresp;
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        logic [1:0]        rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [SLOT_W-1:0] slot;
        logic [DATA_W-1:0] operand; // unsigned Q16.16 value.
    } job_t;

    typedef struct packed {
        logic [SLOT_W-1:0] slot;
        logic [DATA_W-1:0] root;
    } result_t;

endpackage

`default_nettype wire

// File: testbench/sqrt_accel_chk.sv
`timescale 1ns/1ps
`default_nettype none

module sqrt_accel_chk #(
    parameter int NUM_ENGINES = 2
) (
    input wire logic                   clk,
    input wire logic                   rst_n,
    input wire sqrt_pkg::axil_req_t    axil_req,
    input wire sqrt_pkg::axil_rsp_t    axil_rsp,
    input wire logic [NUM_ENGINES-1:0] go,
    input wire logic [NUM_ENGINES-1:0] req,
    input wire logic [NUM_ENGINES-1:0] gnt,
    input wire logic                   wr_en
);
    reset_quiet: assert property (@(posedge clk) !rst_n |=>
        !axil_rsp.bvalid && !axil_rsp.rvalid && !axil_rsp.awready && !axil_rsp.arready &&
        go == '0 && req == '0 && !wr_en)
        else $error("control outputs active right after a reset cycle");

    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else $error("rvalid or rdata changed before rready");

    resp_okay: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bresp == sqrt_pkg::RESP_OKAY && axil_rsp.rresp == sqrt_pkg::RESP_OKAY)
        else $error("response code is not OKAY");

    go_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(go))
        else $error("go pulsed more than one engine");

    gnt_legal: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(gnt) && (gnt & ~req) == '0)
        else $error("arbiter grant is not one-hot or went to an idle engine");

endmodule

bind sqrt_accel sqrt_accel_chk #(.NUM_ENGINES(NUM_ENGINES)) chk_i (
    .clk(clk), .rst_n(rst_n), .axil_req(axil_req), .axil_rsp(axil_rsp),
    .go(go), .req(req), .gnt(gnt), .wr_en(wr_en)
);

`default_nettype wire

// File: testbench/sqrt_accel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sqrt_accel_tb;
    localparam int NUM_ENGINES = 2;
    localparam int FRAC_WIDTH = 16;
    localparam int ITERATIONS = (sqrt_pkg::DATA_W + FRAC_WIDTH) / 2;
    localparam int NUM_JOBS = 50; // known, concurrency, reuse and soak jobs.
    localparam int TIMEOUT_CYCLES = NUM_JOBS * (ITERATIONS + 40) + 500;

    logic                clk, rst_n;
    sqrt_pkg::axil_req_t axil_req;
    sqrt_pkg::axil_rsp_t axil_rsp;
    integer              seed;
    logic [31:0]         status, root_word, op_a, op_b;
    logic [3:0]          slot_a, slot_b;
    logic [31:0]         known [6] = '{32'h0000_0000, 32'h0001_0000, 32'h0002_0000,
                                       32'h0004_0000, 32'h0000_4000, 32'hffff_ffff};

    tb_clk_gen #(.PERIOD(8), .RESET_CYCLES(3)) clk_gen_i (.clk(clk), .rst_n(rst_n));

    sqrt_accel #(.NUM_ENGINES(NUM_ENGINES), .FRAC_WIDTH(FRAC_WIDTH)) dut_i (
        .clk(clk), .rst_n(rst_n), .axil_req(axil_req), .axil_rsp(axil_rsp)
    );

    // floor of sqrt(op * 2**FRAC_WIDTH), found one root bit at a time from the top.
    function automatic logic [31:0] ref_root(input logic [31:0] op);
        logic [63:0] x;
        logic [31:0] r, cand;
        x = {32'd0, op} << FRAC_WIDTH;
        r = '0;
        for (int b = 31; b >= 0; b--) begin
            cand = r | (32'd1 << b);
            if ({32'd0, cand} * {32'd0, cand} <= x) r = cand;
        end
        return r;
    endfunction

    function automatic logic [sqrt_pkg::ADDR_W-1:0] slot_addr(input logic [3:0] slot);
        return sqrt_pkg::SLOT_BASE + {slot, 2'b00};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else fail_run($sformatf("mismatch at %0t: %s expected %h got %h",
                                                     $time, name, exp, got));
    endtask

    task automatic write_job(input logic [3:0] slot, input logic [31:0] op, input int hold);
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr <= slot_addr(slot);
        axil_req.wvalid <= 1'b1;
        axil_req.wdata <= op;
        @(negedge clk);
        while (!(axil_rsp.awready && axil_rsp.wready)) @(negedge clk); // stalls while all busy.
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.bvalid) @(negedge clk);
        repeat (hold) @(negedge clk);
        @(posedge clk);
        axil_req.bready <= 1'b1;
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic read_word(input logic [sqrt_pkg::ADDR_W-1:0] addr, input int hold,
                             output logic [31:0] data);
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr <= addr;
        @(negedge clk);
        while (!axil_rsp.arready) @(negedge clk);
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.rvalid) @(negedge clk);
        repeat (hold) @(negedge clk);
        data = axil_rsp.rdata;
        @(posedge clk);
        axil_req.rready <= 1'b1;
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    task automatic poll_valid(input logic [3:0] slot);
        logic [31:0] word;
        read_word(sqrt_pkg::STATUS_ADDR, 0, word);
        while (!word[slot]) read_word(sqrt_pkg::STATUS_ADDR, 0, word);
    endtask

    task automatic check_root(input logic [3:0] slot, input logic [31:0] op, input int hold);
        logic [31:0] data;
        poll_valid(slot);
        read_word(slot_addr(slot), hold, data);
        check_value($sformatf("slot %0d root", slot), ref_root(op), data);
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_run($sformatf("run timed out after %0d cycles", TIMEOUT_CYCLES));
    end

    initial begin
        axil_req = '0;
        seed = 32'h2644_a257;
        @(posedge rst_n);
        @(negedge clk);
        check_value("bvalid", 0, 32'(axil_rsp.bvalid));
        check_value("rvalid", 0, 32'(axil_rsp.rvalid));
        read_word(sqrt_pkg::STATUS_ADDR, 0, status);
        check_value("status", 0, status);
        for (int i = 0; i < 6; i++) write_job(4'(i), known[i], i % 2);
        for (int i = 0; i < 6; i++) check_root(4'(i), known[i], i % 3);
        read_word(slot_addr(4'd2), 0, root_word);
        check_value("slot 2 root", 32'h0001_6a09, root_word); // square root of 2.0.
        read_word(slot_addr(4'd3), 1, root_word);
        check_value("slot 3 root", 32'h0002_0000, root_word);
        // two jobs fill both engines, so the third has to wait for a grant.
        write_job(4'd8, 32'h0009_0000, 0);
        write_job(4'd9, 32'h0000_c000, 1);
        read_word(sqrt_pkg::STATUS_ADDR, 0, status);
        check_value("busy mask", 32'h3, 32'(status[17:16]));
        write_job(4'd10, 32'h0123_4567, 0);
        read_word(sqrt_pkg::STATUS_ADDR, 0, status);
        check_value("slot 8 or 9 valid", 1, 32'(status[8] | status[9]));
        check_root(4'd8, 32'h0009_0000, 0);
        check_root(4'd9, 32'h0000_c000, 1);
        check_root(4'd10, 32'h0123_4567, 2);
        write_job(4'd3, 32'h0009_0000, 0); // slot 3 still holds the root of 4.0.
        read_word(sqrt_pkg::STATUS_ADDR, 0, status);
        check_value("slot 3 valid bit", 0, 32'(status[3]));
        check_root(4'd3, 32'h0009_0000, 2);
        for (int i = 0; i < 20; i++) begin
            op_a = $random(seed);
            op_b = $random(seed);
            slot_a = 4'($random(seed));
            slot_b = slot_a + 4'd1 + 4'($unsigned($random(seed)) % 15); // never slot_a.
            write_job(slot_a, op_a, 0);
            write_job(slot_b, op_b, i % 2);
            check_root(slot_a, op_a, i % 3);
            check_root(slot_b, op_b, 0);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1; // released on a rising edge like any other synchronous input.
    end

endmodule

`default_nettype wire

// File: verilog.f
source/sqrt_pkg.sv
source/fp_sqrt.sv
source/axil_regs.sv
source/result_arbiter.sv
source/result_mem.sv
source/sqrt_accel.sv
testbench/tb_clk_gen.sv
testbench/sqrt_accel_chk.sv
testbench/sqrt_accel_tb.sv
